// File: rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B              // lui
  } alu_op_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_t;             // Matches funct3[1:0] of loads and stores

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam word_t EBREAK_WORD = 32'h0010_0073;

endpackage

// File: rv_bus_pkg.sv
package rv_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [7:0]  mem_idx_t;     // Word index, address bits 9:2
  typedef logic [3:0]  byte_mask_t;

  localparam int    MEM_WORDS = 256;
  localparam addr_t MEM_BASE  = 32'h8000_0000;
  localparam addr_t RESET_PC  = MEM_BASE;

endpackage

// File: rv_decoder.sv
`timescale 1ns/1ns
module rv_decoder (
  input  rv_isa_pkg::word_t     instr,
  output rv_isa_pkg::alu_op_t   alu_op,
  output rv_isa_pkg::word_t     imm,
  output rv_isa_pkg::reg_idx_t  rs1,
  output rv_isa_pkg::reg_idx_t  rs2,
  output rv_isa_pkg::reg_idx_t  rd,
  output logic                  use_imm,
  output logic                  use_pc,
  output logic                  reg_wen,
  output logic                  is_load,
  output logic                  is_store,
  output logic                  is_branch,
  output logic                  is_jal,
  output logic                  is_jalr,
  output logic                  is_ebreak,
  output logic                  illegal,
  output logic [2:0]            funct3,
  output rv_isa_pkg::mem_size_t size,
  output logic                  load_unsigned
);
  import rv_isa_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic alu_op_t f3_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode        = instr[6:0];
  assign funct3        = instr[14:12];
  assign funct7        = instr[31:25];
  assign rs1           = instr[19:15];
  assign rs2           = instr[24:20];
  assign rd            = instr[11:7];
  assign f7_zero       = funct7 == 7'b0000000;
  assign f7_alt        = funct7 == 7'b0100000;
  assign size          = mem_size_t'(funct3[1:0]);
  assign load_unsigned = funct3[2];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_op    = ALU_ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    reg_wen   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OP_LUI: begin
        alu_op  = ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        reg_wen = 1'b1;
      end
      OP_AUIPC: begin
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        reg_wen = 1'b1;
      end
      OP_JAL: begin
        imm     = imm_j;
        is_jal  = 1'b1;
        reg_wen = 1'b1;
      end
      OP_JALR: begin
        use_imm = 1'b1;                             // Target from the ALU sum
        is_jalr = funct3 == 3'b000;
        reg_wen = funct3 == 3'b000;
        illegal = funct3 != 3'b000;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        is_branch = funct3[2:1] != 2'b01;
        illegal   = funct3[2:1] == 2'b01;
      end
      OP_LOAD: begin
        use_imm = 1'b1;
        is_load = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        reg_wen = is_load;
        illegal = !is_load;
      end
      OP_STORE: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = funct3 inside {3'b000, 3'b001, 3'b010};
        illegal  = !is_store;
      end
      OP_IMM: begin
        alu_op  = f3_op(funct3, funct3 == 3'b101 && f7_alt);
        use_imm = 1'b1;
        illegal = (funct3 == 3'b001 && !f7_zero) ||
                  (funct3 == 3'b101 && !f7_zero && !f7_alt);
        reg_wen = !illegal;
      end
      OP_REG: begin
        alu_op  = f3_op(funct3, f7_alt);
        illegal = !(f7_zero || (f7_alt && funct3 inside {3'b000, 3'b101}));
        reg_wen = !illegal;
      end
      OP_SYSTEM: begin
        is_ebreak = instr == EBREAK_WORD;
        illegal   = instr != EBREAK_WORD;          // ecall, CSRs
      end
      default: illegal = 1'b1;                      // fence and unknown opcodes
    endcase
  end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ns
module rv_regfile (
  input  logic                 clk,
  input  logic                 arst_n,
  input  rv_isa_pkg::reg_idx_t raddr1,
  input  rv_isa_pkg::reg_idx_t raddr2,
  input  rv_isa_pkg::reg_idx_t waddr,
  input  logic                 wen,
  input  rv_isa_pkg::word_t    wdata,
  output rv_isa_pkg::word_t    rdata1,
  output rv_isa_pkg::word_t    rdata2
);
  import rv_isa_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && waddr != '0) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  a_wdata_known: assert property (@(posedge clk) disable iff (!arst_n)
    wen && waddr != '0 |-> !$isunknown(wdata));

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ns
module rv_lsu (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   start,
  input  logic                   we,
  input  rv_isa_pkg::mem_size_t  size,
  input  logic                   load_unsigned,
  input  rv_bus_pkg::addr_t      addr,
  input  rv_isa_pkg::word_t      store_data,
  output logic                   done,
  output rv_isa_pkg::word_t      load_data,
  output logic                   d_req,
  output rv_bus_pkg::addr_t      d_addr,
  output logic                   d_we,
  output rv_isa_pkg::word_t      d_wdata,
  output rv_bus_pkg::byte_mask_t d_mask,
  input  logic                   d_ack,
  input  rv_isa_pkg::word_t      d_rdata
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  logic       ack_seen;     // Waiting for ack low after req dropped
  logic [1:0] offset;
  logic       unsigned_q;
  mem_size_t  size_q;
  word_t      rdata_q;
  word_t      lane;
  byte_mask_t mask;

  always_comb begin
    case (size)
      SIZE_BYTE: mask = 4'b0001 << addr[1:0];
      SIZE_HALF: mask = 4'b0011 << addr[1:0];
      default:   mask = 4'b1111;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_req    <= 1'b0;
      ack_seen <= 1'b0;
    end else if (start) begin
      d_req <= 1'b1;
    end else if (d_req && d_ack) begin
      d_req    <= 1'b0;
      ack_seen <= 1'b1;
    end else if (ack_seen && !d_ack) begin
      ack_seen <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      d_addr     <= {addr[31:2], 2'b00};
      d_we       <= we;
      d_wdata    <= store_data << {addr[1:0], 3'b000};  // Into the byte lane
      d_mask     <= mask;
      offset     <= addr[1:0];
      size_q     <= size;
      unsigned_q <= load_unsigned;
    end
    if (d_req && d_ack)
      rdata_q <= d_rdata;
  end

  assign done = ack_seen && !d_ack;
  assign lane = rdata_q >> {offset, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_BYTE: load_data = {{24{lane[7] & ~unsigned_q}}, lane[7:0]};
      SIZE_HALF: load_data = {{16{lane[15] & ~unsigned_q}}, lane[15:0]};
      default:   load_data = lane;
    endcase
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> !d_req && !ack_seen);

endmodule

// File: rv_core.sv
`timescale 1ns/1ns
module rv_core (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  output logic                   f_req,
  output rv_bus_pkg::addr_t      f_addr,
  input  logic                   f_ack,
  input  rv_isa_pkg::word_t      f_rdata,
  output logic                   d_req,
  output rv_bus_pkg::addr_t      d_addr,
  output logic                   d_we,
  output rv_isa_pkg::word_t      d_wdata,
  output rv_bus_pkg::byte_mask_t d_mask,
  input  logic                   d_ack,
  input  rv_isa_pkg::word_t      d_rdata,
  output rv_isa_pkg::word_t      pc,
  output logic                   retire_valid,
  output rv_isa_pkg::word_t      retire_pc,
  output rv_isa_pkg::reg_idx_t   retire_rd,
  output rv_isa_pkg::word_t      retire_data,
  output logic                   halted,
  output logic                   illegal
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, RETIRE, HALT} state_t;

  state_t     state;
  word_t      instr;
  alu_op_t    alu_op;
  word_t      imm, rdata1, rdata2, op_a, op_b, alu_res;
  word_t      load_data, wb_data, next_pc;
  reg_idx_t   rs1, rs2, rd;
  logic [2:0] funct3;
  mem_size_t  size;
  logic       use_imm, use_pc, reg_wen, is_load, is_store, is_branch;
  logic       is_jal, is_jalr, is_ebreak, dec_illegal, load_unsigned;
  logic       mem_op, misaligned, cond, taken, lsu_done;

  rv_decoder i_rv_decoder (
    .instr(instr), .alu_op(alu_op), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd),
    .use_imm(use_imm), .use_pc(use_pc), .reg_wen(reg_wen), .is_load(is_load),
    .is_store(is_store), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_ebreak(is_ebreak), .illegal(dec_illegal), .funct3(funct3), .size(size),
    .load_unsigned(load_unsigned)
  );

  rv_regfile i_rv_regfile (
    .clk(clk), .arst_n(arst_n), .raddr1(rs1), .raddr2(rs2), .waddr(rd),
    .wen(retire_valid && reg_wen), .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
  );

  rv_lsu i_rv_lsu (
    .clk(clk), .arst_n(arst_n), .start(state == EXEC && mem_op && !misaligned),
    .we(is_store), .size(size), .load_unsigned(load_unsigned), .addr(alu_res),
    .store_data(rdata2), .done(lsu_done), .load_data(load_data),
    .d_req(d_req), .d_addr(d_addr), .d_we(d_we), .d_wdata(d_wdata), .d_mask(d_mask),
    .d_ack(d_ack), .d_rdata(d_rdata)
  );

  assign op_a = use_pc ? pc : rdata1;
  assign op_b = use_imm ? imm : rdata2;

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  cond = rdata1 == rdata2;
      3'b001:  cond = rdata1 != rdata2;
      3'b100:  cond = $signed(rdata1) < $signed(rdata2);
      3'b101:  cond = $signed(rdata1) >= $signed(rdata2);
      3'b110:  cond = rdata1 < rdata2;
      default: cond = rdata1 >= rdata2;
    endcase
  end

  assign taken      = is_branch && cond;
  assign mem_op     = is_load || is_store;
  assign misaligned = mem_op && ((size == SIZE_HALF && alu_res[0]) ||
                                 (size == SIZE_WORD && alu_res[1:0] != 2'b00));
  assign next_pc    = is_jalr ? {alu_res[31:1], 1'b0} :
                      (is_jal || taken) ? pc + imm : pc + 32'd4;
  assign wb_data    = (is_jal || is_jalr) ? pc + 32'd4 : is_load ? load_data : alu_res;

  // Instruction and operands stay put until the end of RETIRE
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      pc      <= RESET_PC;
      f_req   <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        IDLE: if (run) begin
          state <= FETCH;
          f_req <= 1'b1;
        end
        FETCH: if (f_ack) begin
          state <= EXEC;
          f_req <= 1'b0;
        end
        EXEC: begin
          if (dec_illegal || misaligned) begin
            state   <= HALT;
            illegal <= 1'b1;
          end else if (is_ebreak) begin
            state <= HALT;
          end else begin
            state <= mem_op ? MEM : RETIRE;
          end
        end
        MEM: if (lsu_done) state <= RETIRE;
        RETIRE: begin
          state <= FETCH;
          pc    <= next_pc;
          f_req <= 1'b1;
        end
        default: state <= HALT;                    // Stays until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH && f_ack)
      instr <= f_rdata;
  end

  assign f_addr       = pc;
  assign halted       = state == HALT;
  assign retire_valid = state == RETIRE;
  assign retire_pc    = pc;
  assign retire_rd    = reg_wen ? rd : '0;
  assign retire_data  = (reg_wen && rd != '0) ? wb_data : '0;

endmodule

// File: rv_mem_arbiter.sv
`timescale 1ns/1ns
module rv_mem_arbiter (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   h_req,
  input  logic                   h_we,
  input  rv_bus_pkg::addr_t      h_addr,
  input  rv_isa_pkg::word_t      h_wdata,
  output logic                   h_ack,
  input  logic                   f_req,
  input  rv_bus_pkg::addr_t      f_addr,
  output logic                   f_ack,
  input  logic                   d_req,
  input  logic                   d_we,
  input  rv_bus_pkg::addr_t      d_addr,
  input  rv_isa_pkg::word_t      d_wdata,
  input  rv_bus_pkg::byte_mask_t d_mask,
  output logic                   d_ack,
  output logic                   m_req,
  output logic                   m_we,
  output rv_bus_pkg::addr_t      m_addr,
  output rv_isa_pkg::word_t      m_wdata,
  output rv_bus_pkg::byte_mask_t m_mask,
  input  logic                   m_ack
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  typedef enum logic [1:0] {GNT_NONE, GNT_HOST, GNT_DATA, GNT_FETCH} grant_t;

  grant_t grant;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      grant <= GNT_NONE;
    end else if (grant == GNT_NONE) begin
      if (h_req)
        grant <= GNT_HOST;
      else if (d_req)
        grant <= GNT_DATA;
      else if (f_req)
        grant <= GNT_FETCH;
    end else if (!m_req && !m_ack) begin   // Handshake back to idle
      grant <= GNT_NONE;
    end
  end

  always_comb begin
    m_req   = 1'b0;
    m_we    = 1'b0;
    m_addr  = f_addr;
    m_wdata = '0;
    m_mask  = '0;
    case (grant)
      GNT_HOST: begin
        m_req   = h_req;
        m_we    = h_we;
        m_addr  = h_addr;
        m_wdata = h_wdata;
        m_mask  = 4'b1111;
      end
      GNT_DATA: begin
        m_req   = d_req;
        m_we    = d_we;
        m_addr  = d_addr;
        m_wdata = d_wdata;
        m_mask  = d_mask;
      end
      GNT_FETCH: m_req = f_req;
      default: ;
    endcase
  end

  assign h_ack = grant == GNT_HOST && m_ack;
  assign d_ack = grant == GNT_DATA && m_ack;
  assign f_ack = grant == GNT_FETCH && m_ack;

  a_ack_granted: assert property (@(posedge clk) disable iff (!arst_n)
    m_ack |-> grant != GNT_NONE);

endmodule

// File: rv_sram.sv
`timescale 1ns/1ns
module rv_sram (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   m_req,
  input  logic                   m_we,
  input  rv_bus_pkg::addr_t      m_addr,
  input  rv_isa_pkg::word_t      m_wdata,
  input  rv_bus_pkg::byte_mask_t m_mask,
  output logic                   m_ack,
  output rv_isa_pkg::word_t      m_rdata
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  word_t    mem [MEM_WORDS];
  mem_idx_t idx;
  logic     access;

  assign idx    = m_addr[9:2];          // Wraps outside the region
  assign access = m_req && !m_ack;      // First cycle of a request

  always_ff @(posedge clk) begin
    if (access) begin
      if (m_we) begin
        for (int b = 0; b < 4; b++)
          if (m_mask[b])
            mem[idx][8*b +: 8] <= m_wdata[8*b +: 8];
      end
      m_rdata <= mem[idx];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      m_ack <= 1'b0;
    else
      m_ack <= m_req;
  end

endmodule

// File: rv_soc.sv
`timescale 1ns/1ns
module rv_soc (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 run,
  input  logic                 host_req,
  input  logic                 host_we,
  input  rv_bus_pkg::addr_t    host_addr,
  input  rv_isa_pkg::word_t    host_wdata,
  output logic                 host_ack,
  output rv_isa_pkg::word_t    host_rdata,
  output rv_isa_pkg::word_t    pc,
  output logic                 retire_valid,
  output rv_isa_pkg::word_t    retire_pc,
  output rv_isa_pkg::reg_idx_t retire_rd,
  output rv_isa_pkg::word_t    retire_data,
  output logic                 halted,
  output logic                 illegal
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  logic       f_req, f_ack;
  addr_t      f_addr;
  logic       d_req, d_we, d_ack;
  addr_t      d_addr;
  word_t      d_wdata;
  byte_mask_t d_mask;
  logic       m_req, m_we, m_ack;
  addr_t      m_addr;
  word_t      m_wdata;
  byte_mask_t m_mask;

  // SRAM read data goes to every requester
  rv_core i_rv_core (
    .clk(clk), .arst_n(arst_n), .run(run),
    .f_req(f_req), .f_addr(f_addr), .f_ack(f_ack), .f_rdata(host_rdata),
    .d_req(d_req), .d_addr(d_addr), .d_we(d_we), .d_wdata(d_wdata),
    .d_mask(d_mask), .d_ack(d_ack), .d_rdata(host_rdata),
    .pc(pc), .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data),
    .halted(halted), .illegal(illegal)
  );

  rv_mem_arbiter i_rv_mem_arbiter (
    .clk(clk), .arst_n(arst_n),
    .h_req(host_req), .h_we(host_we), .h_addr(host_addr), .h_wdata(host_wdata),
    .h_ack(host_ack),
    .f_req(f_req), .f_addr(f_addr), .f_ack(f_ack),
    .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
    .d_mask(d_mask), .d_ack(d_ack),
    .m_req(m_req), .m_we(m_we), .m_addr(m_addr), .m_wdata(m_wdata),
    .m_mask(m_mask), .m_ack(m_ack)
  );

  rv_sram i_rv_sram (
    .clk(clk), .arst_n(arst_n),
    .m_req(m_req), .m_we(m_we), .m_addr(m_addr), .m_wdata(m_wdata),
    .m_mask(m_mask), .m_ack(m_ack), .m_rdata(host_rdata)
  );

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ns
module tb_clkgen (
  input  logic rst_req,
  output logic clk,
  output logic arst_n
);
  logic por_n;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;         // 40 ns period
  end

  initial begin
    por_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    por_n = 1'b1;
  end

  assign arst_n = por_n && !rst_req;  // Testbench can reset again later

endmodule

// File: tb_checker.sv
`timescale 1ns/1ns
module tb_checker (
  input logic        clk,
  input logic        arst_n,
  input logic [31:0] pc,
  input logic        retire_valid,
  input logic [31:0] retire_pc,
  input logic [4:0]  retire_rd,
  input logic [31:0] retire_data,
  input logic        halted,
  input logic        illegal
);
  int          errors;
  int          checks;
  logic [31:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];

  initial begin
    errors = 0;
    checks = 0;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic push_retire(input logic [31:0] p, input logic [4:0] rd, input logic [31:0] d);
    exp_pc.push_back(p);
    exp_rd.push_back(rd);
    exp_data.push_back(d);
  endtask

  task automatic check_word(input logic [31:0] addr, input logic [31:0] got,
                            input logic [31:0] exp);
    compare($sformatf("host_rdata[%h]", addr), got, exp);
  endtask

  task automatic check_status(input logic h, input logic i, input logic [31:0] p);
    compare("halted", {31'b0, halted}, {31'b0, h});
    compare("illegal", {31'b0, illegal}, {31'b0, i});
    compare("pc", pc, p);
    if (exp_pc.size() != 0) begin
      errors++;
      $display("%0d expected retires never appeared", exp_pc.size());
      exp_pc.delete();
      exp_rd.delete();
      exp_data.delete();
    end
  endtask

  // Retire signals sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n && retire_valid) begin
      if (exp_pc.size() == 0) begin
        errors++;
        $display("Unexpected retire of pc %h at %0t ns", retire_pc, $time);
      end else begin
        compare("retire_pc", retire_pc, exp_pc.pop_front());
        compare("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd.pop_front()});
        compare("retire_data", retire_data, exp_data.pop_front());
      end
    end
  end

  task automatic report();
    $display("Checks: %0d, errors: %0d", checks, errors);
  endtask

endmodule

// File: tb_rv_soc.sv
`timescale 1ns/1ns
module tb_rv_soc;
  logic        clk, arst_n, rst_req, run;
  logic        host_req, host_we, host_ack;
  logic [31:0] host_addr, host_wdata, host_rdata;
  logic [31:0] pc, retire_pc, retire_data;
  logic [4:0]  retire_rd;
  logic        retire_valid, halted, illegal;
  bit          aborted;

  tb_clkgen i_tb_clkgen (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

  rv_soc i_rv_soc (
    .clk(clk), .arst_n(arst_n), .run(run),
    .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
    .pc(pc), .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data),
    .halted(halted), .illegal(illegal)
  );

  tb_checker i_tb_checker (
    .clk(clk), .arst_n(arst_n), .pc(pc), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_data(retire_data),
    .halted(halted), .illegal(illegal)
  );

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (host_ack !== level && !aborted) begin
      @(negedge clk);
      n++;
      if (n > 100) begin
        $display("Timeout: host_ack did not go to %0b", level);
        aborted = 1;
      end
    end
  endtask

  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    wait_ack(1'b1);
    rdata    = host_rdata;
    host_req = 1'b0;
    host_we  = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    while (halted !== 1'b1 && !aborted) begin
      @(negedge clk);
      n++;
      if (n > 3000) begin
        $display("Timeout: core never halted");
        aborted = 1;
      end
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (arst_n !== 1'b1 && !aborted) begin
      @(negedge clk);
      n++;
      if (n > 10) begin
        $display("Timeout: reset never released");
        aborted = 1;
      end
    end
  endtask

  initial begin
    int                 fd;
    int                 rc;
    logic [8*8-1:0]     tok;
    logic [8*200-1:0]   line;
    logic [31:0]        a, b, c, rdata;
    rst_req    = 1'b0;
    run        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    aborted    = 0;
    wait_reset_release();
    fd = $fopen("rv_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open rv_golden.txt");
      aborted = 1;
    end
    while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
      case (tok)
        "#": rc = $fgets(line, fd);
        "L": begin
          rc = $fscanf(fd, "%h %h", a, b);
          host_access(1'b1, a, b, rdata);
        end
        "E": begin
          rc = $fscanf(fd, "%h %h %h", a, b, c);
          i_tb_checker.push_retire(a, b[4:0], c);
        end
        "R": begin
          @(negedge clk);
          run = 1'b1;
        end
        "W": wait_halt();
        "M": begin
          rc = $fscanf(fd, "%h %h", a, b);
          host_access(1'b0, a, 32'h0, rdata);
          if (!aborted)
            i_tb_checker.check_word(a, rdata, b);
        end
        "H": begin
          rc = $fscanf(fd, "%h %h %h", a, b, c);
          i_tb_checker.check_status(a[0], b[0], c);
        end
        "X": begin
          @(negedge clk);
          run     = 1'b0;
          rst_req = 1'b1;
          repeat (2) @(negedge clk);
          rst_req = 1'b0;
          wait_reset_release();
        end
        default: begin
          $display("Unknown record %0s in rv_golden.txt", tok);
          aborted = 1;
        end
      endcase
    end
    if (fd != 0)
      $fclose(fd);
    i_tb_checker.report();
    if (aborted || i_tb_checker.errors != 0)
      $display("Something failed");
    else
      $display("Everything OK");
    $finish;
  end

endmodule

// File: sources.f
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_lsu.sv
rv_core.sv
rv_mem_arbiter.sv
rv_sram.sv
rv_soc.sv
tb_clkgen.sv
tb_checker.sv
tb_rv_soc.sv

// File: rv_golden.txt
# L addr word: host write | E pc rd data: expected retire | R: run | W: wait for halt
# M addr word: host read check | H halted illegal pc: final state | X: reset
L 80000000 800000B7
L 80000004 20008093
L 80000008 FFB00113
L 8000000C 00300193
L 80000010 00312233
L 80000014 003132B3
L 80000018 40218333
L 8000001C 403153B3
L 80000020 01C15413
L 80000024 FFF14493
L 80000028 00318033
L 8000002C FFF13513
L 80000030 00001597
L 80000034 00314463
L 80000038 00100613
L 8000003C 00316463
L 80000040 008006EF
L 80000044 00100613
L 80000048 00000717
L 8000004C 00D707E7
L 80000050 00100613
L 80000054 00318463
L 80000058 00100613
L 8000005C 00319463
L 80000060 00315463
L 80000064 00317463
L 80000068 00100613
L 8000006C 006080A3
L 80000070 002081A3
L 80000074 00909323
L 80000078 00308023
L 8000007C 00208123
L 80000080 00209223
L 80000084 0020A423
L 80000088 00308803
L 8000008C 0030C883
L 80000090 00209903
L 80000094 0020D983
L 80000098 0040AA03
L 8000009C 00008A83
L 800000A0 00100073
L 80000200 AAAAAAAA
L 80000204 AAAAAAAA
L 80000208 00000000
L 8000020C AAAAAAAA
E 80000000 01 80000000
E 80000004 01 80000200
E 80000008 02 FFFFFFFB
E 8000000C 03 00000003
E 80000010 04 00000001
E 80000014 05 00000000
E 80000018 06 00000008
E 8000001C 07 FFFFFFFF
E 80000020 08 0000000F
E 80000024 09 00000004
E 80000028 00 00000000
E 8000002C 0A 00000001
E 80000030 0B 80001030
E 80000034 00 00000000
E 8000003C 00 00000000
E 80000040 0D 80000044
E 80000048 0E 80000048
E 8000004C 0F 80000050
E 80000054 00 00000000
E 8000005C 00 00000000
E 80000060 00 00000000
E 80000064 00 00000000
E 8000006C 00 00000000
E 80000070 00 00000000
E 80000074 00 00000000
E 80000078 00 00000000
E 8000007C 00 00000000
E 80000080 00 00000000
E 80000084 00 00000000
E 80000088 10 FFFFFFFB
E 8000008C 11 000000FB
E 80000090 12 FFFFFBFB
E 80000094 13 0000FBFB
E 80000098 14 0004FFFB
E 8000009C 15 00000003
R
# Host reads while the core is running
M 80000000 800000B7
M 80000084 0020A423
M 80000040 008006EF
W
M 80000200 FBFB0803
M 80000204 0004FFFB
M 80000208 FFFFFFFB
M 8000020C AAAAAAAA
H 1 0 800000A0
# Misaligned lw after reset
X
L 80000000 00100093
L 80000004 0020A103
E 80000000 01 00000001
R
W
H 1 1 80000004
# Illegal encoding after reset
X
L 80000004 FFFFFFFF
E 80000000 01 00000001
R
W
H 1 1 80000004
